//--- Bender.yml
package:
  name: limb_link

sources:
  - source/limb_pkg.sv
  - source/host_regs.sv
  - source/sim_sequencer.sv
  - source/wave_buffer.sv
  - source/spi_tx.sv
  - source/spi_rx.sv
  - source/limb_link_top.sv

  - target: simulation
    files:
      - tb/tb_limb_link.sv

//--- sim.f
source/limb_pkg.sv
source/host_regs.sv
source/sim_sequencer.sv
source/wave_buffer.sv
source/spi_tx.sv
source/spi_rx.sv
source/limb_link_top.sv
tb/tb_limb_link.sv

//--- source/host_regs.sv
`timescale 1ns/1ns
module host_regs (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  limb_pkg::wb_req_t           i_wb,
    output limb_pkg::wb_rsp_t           o_wb,
    output logic                        o_run,
    output logic                        o_restart,
    output logic [15:0]                 o_half_cnt,
    output logic                        o_push,
    output logic [limb_pkg::WORD_W-1:0] o_push_data,
    input  logic [limb_pkg::WORD_W-1:0] i_len,
    input  logic [limb_pkg::FILL_W-1:0] i_fill,
    input  logic [limb_pkg::WORD_W-1:0] i_bic_rate,
    input  logic [limb_pkg::WORD_W-1:0] i_tri_rate,
    input  logic                        i_snap
);
    import limb_pkg::*;

    logic              ack_q;
    logic              acc;     // new access this cycle
    logic              wr;
    reg_addr_e         addr;
    logic [WORD_W-1:0] rd_mux;
    logic [WORD_W-1:0] rd_q;
    logic [WORD_W-1:0] bic_rate_q;
    logic [WORD_W-1:0] tri_rate_q;
    logic [15:0]       frame_cnt;

    assign acc  = i_wb.cyc && i_wb.stb && !ack_q;  // one ack per strobe
    assign wr   = acc && i_wb.we;
    assign addr = reg_addr_e'(i_wb.adr);

    assign o_wb = '{ack: ack_q, dat: rd_q};

    always_comb begin
        case (addr)
            CTRL:     rd_mux = {{(WORD_W-1){1'b0}}, o_run};  // restart reads back 0
            HALF_CNT: rd_mux = {16'd0, o_half_cnt};
            LEN:      rd_mux = i_len;
            BIC_RATE: rd_mux = bic_rate_q;
            TRI_RATE: rd_mux = tri_rate_q;
            STATUS:   rd_mux = {{(WORD_W-16-FILL_W){1'b0}}, i_fill, frame_cnt};
            default:  rd_mux = '0;  // push port and unmapped
        endcase
    end

    //////////////////////////////////////////////////
    // bus handshake and control registers
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            ack_q      <= 1'b0;
            o_run      <= 1'b0;
            o_restart  <= 1'b0;
            o_push     <= 1'b0;
            o_half_cnt <= HALF_CNT_DEFAULT;
        end else begin
            ack_q     <= acc;
            o_restart <= wr && (addr == CTRL) && i_wb.dat[1];
            o_push    <= wr && (addr == WAVE_PUSH);
            if (wr && addr == CTRL) begin
                o_run <= i_wb.dat[0];
            end
            if (wr && addr == HALF_CNT) begin
                o_half_cnt <= i_wb.dat[15:0];
            end
        end
    end

    always_ff @(posedge ep50trig) begin
        if (wr) begin
            o_push_data <= i_wb.dat;  // qualified by o_push
        end
        if (acc) begin
            rd_q <= rd_mux;
        end
    end

    // snapshot at frame end, host sees stable rates
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            bic_rate_q <= '0;
            tri_rate_q <= '0;
            frame_cnt  <= '0;
        end else if (i_snap) begin
            bic_rate_q <= i_bic_rate;
            tri_rate_q <= i_tri_rate;
            frame_cnt  <= frame_cnt + 16'd1;
        end
    end

    a_ack_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_wb.ack |=> !o_wb.ack);

endmodule

//--- source/limb_link_top.sv
`timescale 1ns/1ns
module limb_link_top (
    input  logic               ep50trig,
    input  logic               reset_global,
    input  limb_pkg::wb_req_t  i_wb,
    output limb_pkg::wb_rsp_t  o_wb,
    input  limb_pkg::spi_in_t  i_spi_bic,
    input  limb_pkg::spi_in_t  i_spi_tri,
    output limb_pkg::spi_out_t o_spi_bic,
    output limb_pkg::spi_out_t o_spi_tri
);
    import limb_pkg::*;

    logic              run;
    logic              restart;
    logic [15:0]       half_cnt;
    logic              push;
    logic [WORD_W-1:0] push_data;
    logic              pop;
    logic              empty;
    logic [FILL_W-1:0] fill;
    logic [WORD_W-1:0] sample;
    logic [WORD_W-1:0] len;
    logic              tx_start;
    logic              bic_done;
    logic              tri_done;
    logic              snap;
    logic [WORD_W-1:0] bic_word;
    logic [WORD_W-1:0] tri_word;

    host_regs regs0 (
        .ep50trig, .reset_global, .i_wb, .o_wb,
        .o_run(run), .o_restart(restart), .o_half_cnt(half_cnt),
        .o_push(push), .o_push_data(push_data), .i_len(len), .i_fill(fill),
        .i_bic_rate(bic_word), .i_tri_rate(tri_word), .i_snap(snap)
    );

    sim_sequencer seq0 (
        .ep50trig, .reset_global, .i_run(run), .i_half_cnt(half_cnt),
        .i_empty(empty), .o_pop(pop), .o_tx_start(tx_start),
        .i_bic_done(bic_done), .i_tri_done(tri_done), .o_snap(snap)
    );

    wave_buffer wave0 (
        .ep50trig, .reset_global, .i_push(push), .i_push_data(push_data),
        .i_restart(restart), .i_pop(pop), .o_sample(sample), .o_len(len),
        .o_empty(empty), .o_fill(fill)
    );

    //////////////////////////////////////////////////
    // muscle board links, same sample to both sides
    //////////////////////////////////////////////////
    spi_tx tx_bic (.ep50trig, .reset_global, .i_start(tx_start), .i_data(sample),
                   .o_spi(o_spi_bic), .o_done(bic_done));
    spi_tx tx_tri (.ep50trig, .reset_global, .i_start(tx_start), .i_data(sample),
                   .o_spi(o_spi_tri), .o_done(tri_done));

    spi_rx rx_bic (.ep50trig, .reset_global, .i_spi(i_spi_bic), .o_word(bic_word),
                   .o_valid());  // word held until next frame
    spi_rx rx_tri (.ep50trig, .reset_global, .i_spi(i_spi_tri), .o_word(tri_word),
                   .o_valid());

endmodule

//--- source/limb_pkg.sv
package limb_pkg;

    //////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////
    localparam int WORD_W     = 32;  // samples, rates, bus data
    localparam int ADR_W      = 3;   // word address
    localparam int WAVE_DEPTH = 64;
    localparam int WAVE_AW    = 6;
    localparam int FILL_W     = 7;   // 0 .. 64

    // spi sck half period in clocks, divider 13 plus one
    localparam int SPI_HALF = 14;

    localparam logic [15:0] HALF_CNT_DEFAULT = 16'd100;  // frame gap after reset

    //////////////////////////////////////////////////
    // register map and fsm states
    //////////////////////////////////////////////////
    typedef enum logic [ADR_W-1:0] {
        CTRL      = 3'd0,  // bit 0 run, bit 1 restart
        HALF_CNT  = 3'd1,
        WAVE_PUSH = 3'd2,
        LEN       = 3'd3,
        BIC_RATE  = 3'd4,
        TRI_RATE  = 3'd5,
        STATUS    = 3'd6   // fill level and frame count
    } reg_addr_e;

    typedef enum logic [2:0] {IDLE, GAP, LOAD, SEND, SNAP} seq_state_e;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADR_W-1:0]  adr;
        logic [WORD_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic sck;
        logic mosi;
        logic ssel_n;
    } spi_out_t;

    typedef struct packed {
        logic sck;
        logic mosi;
        logic ssel_n;
    } spi_in_t;

endpackage

//--- source/sim_sequencer.sv
`timescale 1ns/1ns
module sim_sequencer (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_run,
    input  logic [15:0] i_half_cnt,
    input  logic        i_empty,
    output logic        o_pop,
    output logic        o_tx_start,
    input  logic        i_bic_done,
    input  logic        i_tri_done,
    output logic        o_snap
);
    import limb_pkg::*;

    seq_state_e  state;
    logic [15:0] gap_cnt;
    logic        started;   // start already issued this frame
    logic        bic_seen;
    logic        tri_seen;
    logic        both_done;

    assign both_done  = (bic_seen || i_bic_done) && (tri_seen || i_tri_done);
    assign o_pop      = (state == LOAD);
    assign o_tx_start = (state == SEND) && !started;
    assign o_snap     = (state == SNAP);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state    <= IDLE;
            gap_cnt  <= '0;
            started  <= 1'b0;
            bic_seen <= 1'b0;
            tri_seen <= 1'b0;
        end else begin
            case (state)
                IDLE: if (i_run && !i_empty) begin
                    state   <= GAP;
                    gap_cnt <= i_half_cnt;
                end
                GAP: begin
                    // run only looked at here and in IDLE
                    if (!i_run || i_empty) begin
                        state <= IDLE;
                    end else if (gap_cnt <= 16'd1) begin
                        state <= LOAD;
                    end else begin
                        gap_cnt <= gap_cnt - 16'd1;
                    end
                end
                LOAD: begin
                    state    <= SEND;
                    started  <= 1'b0;
                    bic_seen <= 1'b0;
                    tri_seen <= 1'b0;
                end
                SEND: begin
                    started <= 1'b1;
                    if (i_bic_done) bic_seen <= 1'b1;
                    if (i_tri_done) tri_seen <= 1'b1;
                    if (both_done) state <= SNAP;
                end
                SNAP: begin
                    state   <= GAP;         // next frame
                    gap_cnt <= i_half_cnt;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_pop_nonempty: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_pop |-> !i_empty);

endmodule

//--- source/spi_rx.sv
`timescale 1ns/1ns
module spi_rx (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  limb_pkg::spi_in_t           i_spi,
    output logic [limb_pkg::WORD_W-1:0] o_word,
    output logic                        o_valid
);
    import limb_pkg::*;

    spi_in_t           sync1;
    spi_in_t           sync2;
    logic              prev_sck;
    logic              prev_ssel_n;
    logic              sck_rise;
    logic              sel_rise;   // end of frame
    logic [5:0]        bit_cnt;
    logic [WORD_W-1:0] shreg;

    assign sck_rise = sync2.sck && !prev_sck && !sync2.ssel_n;
    assign sel_rise = sync2.ssel_n && !prev_ssel_n;

    //////////////////////////////////////////////////
    // pin synchronizers and edge history
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sync1       <= '{sck: 1'b0, mosi: 1'b0, ssel_n: 1'b1};
            sync2       <= '{sck: 1'b0, mosi: 1'b0, ssel_n: 1'b1};
            prev_sck    <= 1'b0;
            prev_ssel_n <= 1'b1;
        end else begin
            sync1       <= i_spi;
            sync2       <= sync1;
            prev_sck    <= sync2.sck;
            prev_ssel_n <= sync2.ssel_n;
        end
    end

    always_ff @(posedge ep50trig) begin
        if (sck_rise) begin
            shreg <= {shreg[WORD_W-2:0], sync2.mosi};  // msb first
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            bit_cnt <= '0;
            o_word  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (sel_rise && bit_cnt == 6'(WORD_W)) begin
                o_word  <= shreg;
                o_valid <= 1'b1;
            end
            // short or long frames never reach the check above
            if (sync2.ssel_n) begin
                bit_cnt <= '0;
            end else if (sck_rise && bit_cnt <= 6'(WORD_W)) begin
                bit_cnt <= bit_cnt + 6'd1;  // stops past 33
            end
        end
    end

endmodule

//--- source/spi_tx.sv
`timescale 1ns/1ns
module spi_tx (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_start,
    input  logic [limb_pkg::WORD_W-1:0] i_data,
    output limb_pkg::spi_out_t          o_spi,
    output logic                        o_done
);
    import limb_pkg::*;

    logic                        busy;
    logic [$clog2(SPI_HALF)-1:0] hcnt;
    logic [6:0]                  half_idx;  // 0 .. 66
    logic [6:0]                  idx_next;
    logic                        half_end;
    logic                        sck_fall;
    logic [WORD_W-1:0]           shreg;
    spi_out_t                    spi_q;

    assign half_end = busy && (int'(hcnt) == SPI_HALF - 1);
    assign idx_next = half_idx + 7'd1;
    // odd halves after the first are sck falling edges
    assign sck_fall = half_end && idx_next[0] && (idx_next != 7'd1);
    assign o_spi    = spi_q;

    //////////////////////////////////////////////////
    // frame timing, 66 half periods
    // half 0 lead-in, half 1 select, halves 2..65 clock
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            busy     <= 1'b0;
            hcnt     <= '0;
            half_idx <= '0;
            o_done   <= 1'b0;
            spi_q    <= '{sck: 1'b0, mosi: 1'b0, ssel_n: 1'b1};
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy     <= 1'b1;
                hcnt     <= '0;
                half_idx <= '0;
            end else if (busy && half_idx == 7'd66) begin
                busy   <= 1'b0;  // one cycle after ssel_n rises
                o_done <= 1'b1;
            end else if (half_end) begin
                hcnt     <= '0;
                half_idx <= idx_next;
                if (idx_next == 7'd1) begin
                    spi_q.ssel_n <= 1'b0;
                    spi_q.mosi   <= shreg[WORD_W-1];  // msb ready before first rise
                end else if (idx_next == 7'd66) begin
                    spi_q.ssel_n <= 1'b1;
                    spi_q.mosi   <= 1'b0;
                end else if (!idx_next[0]) begin
                    spi_q.sck <= 1'b1;
                end else begin
                    spi_q.sck  <= 1'b0;
                    spi_q.mosi <= shreg[WORD_W-2];
                end
            end else if (busy) begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge ep50trig) begin
        if (i_start) begin
            shreg <= i_data;
        end else if (sck_fall) begin
            shreg <= {shreg[WORD_W-2:0], 1'b0};
        end
    end

    a_no_restart_busy: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_start |-> !busy);

endmodule

//--- source/wave_buffer.sv
`timescale 1ns/1ns
module wave_buffer (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_push,
    input  logic [limb_pkg::WORD_W-1:0] i_push_data,
    input  logic                        i_restart,
    input  logic                        i_pop,
    output logic [limb_pkg::WORD_W-1:0] o_sample,
    output logic [limb_pkg::WORD_W-1:0] o_len,
    output logic                        o_empty,
    output logic [limb_pkg::FILL_W-1:0] o_fill
);
    import limb_pkg::*;

    logic [WORD_W-1:0]  mem [WAVE_DEPTH];
    logic [WAVE_AW-1:0] wr_ptr;
    logic [WAVE_AW-1:0] rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic [FILL_W-1:0]  rd_next;
    logic [WORD_W-1:0]  sample_q;  // last popped word
    logic               push_ok;

    assign push_ok  = i_push && (fill < FILL_W'(WAVE_DEPTH));  // full drops it
    assign rd_next  = FILL_W'(rd_ptr) + FILL_W'(1);
    assign o_empty  = (fill == '0);
    assign o_fill   = fill;
    assign o_sample = sample_q;
    assign o_len    = sample_q;  // host view of the word on the wire

    always_ff @(posedge ep50trig) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            sample_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
                fill   <= fill + 1'b1;
            end
            // replay wraps at the current fill level
            if (i_restart) begin
                rd_ptr <= '0;
            end else if (i_pop) begin
                rd_ptr <= (rd_next >= fill) ? '0 : rd_next[WAVE_AW-1:0];
            end
            if (i_pop) begin
                sample_q <= mem[rd_ptr];
            end
        end
    end

    a_fill_bound: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_fill <= FILL_W'(WAVE_DEPTH));

endmodule

//--- tb/tb_limb_link.sv
`timescale 1ns/1ns
module tb_limb_link;
    import limb_pkg::*;

    localparam int GAP_CYC   = 120;  // frame gap used during replay
    localparam int RX_HALF   = 4;    // clocks per sck half on the inputs
    localparam int N_SAMPLES = 5;
    localparam int N_FRAMES  = 12;
    localparam int FRAME_CYC = GAP_CYC + 66 * SPI_HALF + 10;
    // 16 frames plus idle stretches of about 6 frame times, doubled
    localparam int WDOG_CYC  = 2 * (22 * FRAME_CYC);

    logic     ep50trig;
    logic     reset_global;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    spi_in_t  spi_bic_in;
    spi_in_t  spi_tri_in;
    spi_out_t spi_bic_out;
    spi_out_t spi_tri_out;

    integer      seed;
    int          checks;
    int          mismatches;
    int          failures;
    int          frames_seen;   // frames decoded on the biceps link
    int          compared;
    int          restart_base;  // frame index that replays sample 0
    logic [31:0] samples [N_SAMPLES];
    logic [31:0] bic_q [$];
    logic [31:0] tri_q [$];
    spi_out_t    prev_out [2];
    logic [31:0] rx_word [2];
    int          rx_bits [2];

    limb_link_top dut0 (
        .ep50trig, .reset_global,
        .i_wb(wb_req), .o_wb(wb_rsp),
        .i_spi_bic(spi_bic_in), .i_spi_tri(spi_tri_in),
        .o_spi_bic(spi_bic_out), .o_spi_tri(spi_tri_out)
    );

    always #10 ep50trig = ~ep50trig;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #2;  // inputs move just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // replay order counted from the last restart
    function automatic logic [31:0] expected_sample(input int n);
        int idx;
        idx = (n - restart_base) % N_SAMPLES;
        return samples[idx];
    endfunction

    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [WORD_W-1:0] wdat,
                             output logic [WORD_W-1:0] rdat);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            wait_cycles(1);
            waited++;
        end while (!wb_rsp.ack && waited < 16);
        assert (wb_rsp.ack) else begin
            failures++;
            $display("Wishbone access to address %0d got no ack", adr);
        end
        rdat = wb_rsp.dat;  // valid while ack is high
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [WORD_W-1:0] dat);
        logic [WORD_W-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input logic [ADR_W-1:0] adr, output logic [WORD_W-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    // polls STATUS until the frame count moves
    task automatic wait_frame(inout int count);
        logic [WORD_W-1:0] st;
        int                polls;
        polls = 0;
        do begin
            read_reg(STATUS, st);
            polls++;
        end while (int'(st[15:0]) == count && polls < FRAME_CYC);
        assert (int'(st[15:0]) != count) else begin
            failures++;
            $display("frame count stuck at %0d", count);
        end
        count = int'(st[15:0]);
    endtask

    // both muscle boards answer with the same timing
    task automatic send_rates(input logic [31:0] bic_w, input logic [31:0] tri_w,
                              input int nbits);
        spi_bic_in.ssel_n = 1'b0;
        spi_tri_in.ssel_n = 1'b0;
        for (int k = 0; k < nbits; k++) begin
            spi_bic_in.mosi = bic_w[31-k];  // msb first
            spi_tri_in.mosi = tri_w[31-k];
            wait_cycles(RX_HALF);
            spi_bic_in.sck = 1'b1;
            spi_tri_in.sck = 1'b1;
            wait_cycles(RX_HALF);
            spi_bic_in.sck = 1'b0;
            spi_tri_in.sck = 1'b0;
        end
        wait_cycles(RX_HALF);
        spi_bic_in.ssel_n = 1'b1;
        spi_tri_in.ssel_n = 1'b1;
        spi_bic_in.mosi   = 1'b0;
        spi_tri_in.mosi   = 1'b0;
        wait_cycles(RX_HALF);
    endtask

    //////////////////////////////////////////////////
    // spi frame decoder, sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge ep50trig) begin : decode
        spi_out_t cur;
        for (int i = 0; i < 2; i++) begin
            cur = (i == 0) ? spi_bic_out : spi_tri_out;
            if (reset_global) begin
                prev_out[i] = cur;
                rx_bits[i]  = 0;
            end else begin
                if (!cur.ssel_n && prev_out[i].ssel_n) rx_bits[i] = 0;
                if (!cur.ssel_n && cur.sck && !prev_out[i].sck) begin
                    rx_word[i] = {rx_word[i][30:0], cur.mosi};
                    rx_bits[i]++;
                end
                if (cur.ssel_n && !prev_out[i].ssel_n) begin
                    assert (rx_bits[i] == 32) else begin
                        failures++;
                        $display("output link %0d sent a frame of %0d bits", i, rx_bits[i]);
                    end
                    if (i == 0) begin
                        bic_q.push_back(rx_word[i]);
                        frames_seen++;
                    end else begin
                        tri_q.push_back(rx_word[i]);
                    end
                end
                assert (!(cur.ssel_n && cur.sck)) else begin
                    failures++;
                    $display("output link %0d has sck high while deselected", i);
                end
                prev_out[i] = cur;
            end
        end
    end

    // every decoded pair against the replay order
    always @(posedge ep50trig) begin : compare
        logic [31:0] word_b;
        logic [31:0] word_t;
        logic [31:0] exp;
        if (bic_q.size() > 0 && tri_q.size() > 0) begin
            word_b = bic_q.pop_front();
            word_t = tri_q.pop_front();
            exp    = expected_sample(compared);
            check_value("o_spi_bic word", word_b, exp);
            check_value("o_spi_tri word", word_t, exp);
            compared++;
        end
    end

    initial begin : watchdog
        repeat (WDOG_CYC) @(posedge ep50trig);
        $display("watchdog expired after %0d cycles", WDOG_CYC);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, failures + 1);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin : main
        logic [31:0] rd;
        logic [31:0] bic_w;
        logic [31:0] tri_w;
        logic [31:0] exp_bic;
        logic [31:0] exp_tri;
        int          last_count;
        int          stop_at;
        int          guard;
        seed = 48;
        checks = 0;
        mismatches = 0;
        failures = 0;
        frames_seen = 0;
        compared = 0;
        restart_base = 0;
        reset_global = 1'b1;
        ep50trig = 1'b0;
        wb_req = '0;
        spi_bic_in.sck = 1'b0;
        spi_bic_in.mosi = 1'b0;
        spi_bic_in.ssel_n = 1'b1;
        spi_tri_in = spi_bic_in;
        wait_cycles(3);
        reset_global = 1'b0;

        // reset values and idle links
        check_value("o_spi_bic.ssel_n", spi_bic_out.ssel_n, 1);
        check_value("o_spi_bic.sck", spi_bic_out.sck, 0);
        check_value("o_spi_bic.mosi", spi_bic_out.mosi, 0);
        check_value("o_spi_tri.ssel_n", spi_tri_out.ssel_n, 1);
        check_value("o_spi_tri.sck", spi_tri_out.sck, 0);
        check_value("o_spi_tri.mosi", spi_tri_out.mosi, 0);
        read_reg(CTRL, rd);
        check_value("CTRL", rd, 0);
        read_reg(HALF_CNT, rd);
        check_value("HALF_CNT", rd, 32'(HALF_CNT_DEFAULT));
        read_reg(STATUS, rd);
        check_value("STATUS", rd, 0);

        write_reg(HALF_CNT, GAP_CYC);
        read_reg(HALF_CNT, rd);
        check_value("HALF_CNT", rd, GAP_CYC);
        read_reg(3'd7, rd);
        check_value("unmapped read", rd, 0);

        for (int k = 0; k < N_SAMPLES; k++) begin
            samples[k] = $random(seed);
            write_reg(WAVE_PUSH, samples[k]);
        end
        // samples waiting, run still clear
        wait_cycles(2 * FRAME_CYC);
        check_value("frames while stopped", frames_seen, 0);

        write_reg(CTRL, 32'h1);
        last_count = 0;
        exp_bic = '0;
        exp_tri = '0;
        for (int i = 0; i < N_FRAMES; i++) begin
            wait_frame(last_count);
            read_reg(LEN, rd);
            check_value("LEN", rd, expected_sample(last_count - 1));
            read_reg(BIC_RATE, rd);
            check_value("BIC_RATE", rd, exp_bic);
            read_reg(TRI_RATE, rd);
            check_value("TRI_RATE", rd, exp_tri);
            bic_w = $random(seed);
            tri_w = $random(seed);
            if (i == 5) begin
                send_rates(bic_w, tri_w, 31);  // short frame, dropped
            end else begin
                send_rates(bic_w, tri_w, 32);
                exp_bic = bic_w;
                exp_tri = tri_w;
            end
        end

        // restart right at a frame boundary
        wait_frame(last_count);
        read_reg(BIC_RATE, rd);
        check_value("BIC_RATE", rd, exp_bic);
        read_reg(TRI_RATE, rd);
        check_value("TRI_RATE", rd, exp_tri);
        write_reg(CTRL, 32'h3);
        restart_base = frames_seen;
        check_value("frames decoded", frames_seen, last_count);
        repeat (2) begin
            wait_frame(last_count);
            read_reg(LEN, rd);
            check_value("LEN", rd, expected_sample(last_count - 1));
        end

        // stop while a frame is on the wire
        guard = 0;
        while (spi_bic_out.ssel_n && guard < FRAME_CYC) begin
            wait_cycles(1);
            guard++;
        end
        stop_at = frames_seen;
        write_reg(CTRL, 32'h0);
        wait_cycles(2 * FRAME_CYC);
        check_value("frames after stop", frames_seen, stop_at + 1);
        read_reg(STATUS, rd);
        check_value("STATUS frame count", rd[15:0], frames_seen);
        check_value("STATUS fill", rd[22:16], N_SAMPLES);
        check_value("frames compared", compared, frames_seen);
        check_value("pending o_spi_bic frames", bic_q.size(), 0);
        check_value("pending o_spi_tri frames", tri_q.size(), 0);

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
